/* src/sys_settings.svh */
`ifndef SYS_SETTINGS_SVH
`define SYS_SETTINGS_SVH

// machine CSR addresses.
`define CSR_MSTATUS   12'h300
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MVENDORID 12'hf11
`define CSR_MARCHID   12'hf12

`define MSTATUS_MIE  3  // global interrupt enable.
`define MSTATUS_MPIE 7  // enable saved on trap entry.

// system operation codes carried from decode to execute.
`define SYS_OP_NONE  3'd0
`define SYS_OP_RW    3'd1
`define SYS_OP_RS    3'd2
`define SYS_OP_RC    3'd3
`define SYS_OP_ECALL 3'd4
`define SYS_OP_MRET  3'd5

// fixed encodings of the SYSTEM major opcode.
`define SYS_OPCODE  7'b1110011
`define INSTR_ECALL 32'h0000_0073
`define INSTR_MRET  32'h3020_0073

`define CAUSE_ECALL_M 32'd11  // environment call from machine mode.

`define MVENDORID_VAL 32'h0000_0a11
`define MARCHID_VAL   32'h0000_0001

`endif

/* src/sys_pkg.sv */
package sys_pkg;

  // ********************************************************************
  // widths with a meaning.
  // ********************************************************************

  typedef logic [31:0] xlen_t;      // pc, register and CSR values.
  typedef logic [31:0] instr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  sys_op_t;

  // ********************************************************************
  // records passed between stages.
  // ********************************************************************

  // request into the unit.
  typedef struct packed {
    xlen_t  pc;
    instr_t instr;
    xlen_t  rs1_data;
  } sys_req_t;

  // decoded operation. operand is rs1_data or the zero-extended zimm field.
  typedef struct packed {
    sys_op_t   op;
    csr_addr_t csr_addr;
    reg_idx_t  rd;
    xlen_t     operand;
    logic      write_ok;   // low for set/clear with a zero source field.
    xlen_t     pc;
  } sys_dec_t;

  // result of one instruction.
  typedef struct packed {
    reg_idx_t rd;
    xlen_t    rd_data;
    logic     rd_wen;
    logic     redirect;
    xlen_t    target;
  } sys_res_t;

endpackage

/* src/sys_decode.sv */
`timescale 1ns/10ps
`include "sys_settings.svh"

module sys_decode (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  sys_pkg::sys_req_t in_req,
  output logic              dec_valid,
  output sys_pkg::sys_dec_t dec
);

  sys_pkg::instr_t   instr;
  logic [2:0]        funct3;
  sys_pkg::reg_idx_t rs1;
  logic              is_system;
  sys_pkg::sys_op_t  op_nxt;
  sys_pkg::sys_dec_t dec_nxt;

  assign instr     = in_req.instr;
  assign funct3    = instr[14:12];
  assign rs1       = instr[19:15];  // register index or zimm.
  assign is_system = (instr[6:0] == `SYS_OPCODE);

  // ********************************************************************
  // classification.
  // ********************************************************************

  always_comb begin
    op_nxt = `SYS_OP_NONE;
    if (is_system) begin
      case (funct3)
        3'b001, 3'b101: op_nxt = `SYS_OP_RW;
        3'b010, 3'b110: op_nxt = `SYS_OP_RS;
        3'b011, 3'b111: op_nxt = `SYS_OP_RC;
        3'b000: begin
          // only the exact encodings count, everything else falls through.
          if (instr == `INSTR_ECALL) begin
            op_nxt = `SYS_OP_ECALL;
          end else if (instr == `INSTR_MRET) begin
            op_nxt = `SYS_OP_MRET;
          end
        end
        default: op_nxt = `SYS_OP_NONE;
      endcase
    end
  end

  always_comb begin
    dec_nxt.op       = op_nxt;
    dec_nxt.csr_addr = instr[31:20];
    dec_nxt.rd       = instr[11:7];
    dec_nxt.pc       = in_req.pc;
    if (funct3[2]) begin
      dec_nxt.operand = {27'b0, rs1};  // immediate forms.
    end else begin
      dec_nxt.operand = in_req.rs1_data;
    end
    // set and clear with a zero source must leave the CSR untouched.
    dec_nxt.write_ok = (funct3[1:0] == 2'b01) || (rs1 != 5'd0);
  end

  // ********************************************************************
  // stage register.
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      dec <= dec_nxt;
    end
  end

endmodule

/* src/csr_execute.sv */
`timescale 1ns/10ps
`include "sys_settings.svh"

module csr_execute (
  input  logic               clk,
  input  logic               rst,
  input  logic               dec_valid,
  input  sys_pkg::sys_dec_t  dec,
  input  sys_pkg::xlen_t     rdata,
  input  sys_pkg::xlen_t     mtvec,
  input  sys_pkg::xlen_t     mepc,
  output sys_pkg::csr_addr_t raddr,
  output logic               wen,
  output logic               trap,
  output logic               mret,
  output sys_pkg::csr_addr_t waddr,
  output sys_pkg::csr_addr_t waddr2,
  output sys_pkg::xlen_t     wdata,
  output sys_pkg::xlen_t     wdata2,
  output logic               out_valid,
  output sys_pkg::sys_res_t  out_res
);

  logic              is_csr;
  logic              is_ecall;
  logic              is_mret;
  logic              csr_wen;
  sys_pkg::xlen_t    csr_new;
  sys_pkg::sys_res_t res_nxt;

  assign is_csr   = (dec.op == `SYS_OP_RW) || (dec.op == `SYS_OP_RS) ||
                    (dec.op == `SYS_OP_RC);
  assign is_ecall = dec_valid && (dec.op == `SYS_OP_ECALL);
  assign is_mret  = dec_valid && (dec.op == `SYS_OP_MRET);

  // ********************************************************************
  // CSR read-modify-write.
  // ********************************************************************

  assign raddr = dec.csr_addr;

  always_comb begin
    case (dec.op)
      `SYS_OP_RS: csr_new = rdata | dec.operand;
      `SYS_OP_RC: csr_new = rdata & ~dec.operand;
      default:    csr_new = dec.operand;
    endcase
  end

  assign csr_wen = dec_valid && is_csr && ((dec.op == `SYS_OP_RW) || dec.write_ok);

  // an ECALL needs both ports. a CSR op drives the same write on each.
  assign wen    = csr_wen || is_ecall;
  assign waddr  = is_ecall ? `CSR_MEPC : dec.csr_addr;
  assign wdata  = is_ecall ? dec.pc : csr_new;
  assign waddr2 = is_ecall ? `CSR_MCAUSE : dec.csr_addr;
  assign wdata2 = is_ecall ? `CAUSE_ECALL_M : csr_new;
  assign trap   = is_ecall;
  assign mret   = is_mret;

  // ********************************************************************
  // result.
  // ********************************************************************

  always_comb begin
    res_nxt.rd       = dec.rd;
    res_nxt.rd_data  = rdata;  // old CSR value goes to rd.
    res_nxt.rd_wen   = dec_valid && is_csr && (dec.rd != 5'd0);
    res_nxt.redirect = is_ecall || is_mret;
    res_nxt.target   = is_mret ? mepc : mtvec;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid        <= 1'b0;
      out_res.rd_wen   <= 1'b0;
      out_res.redirect <= 1'b0;
    end else begin
      out_valid <= dec_valid;
      out_res   <= res_nxt;
    end
  end

endmodule

/* src/csr_file.sv */
`timescale 1ns/10ps
`include "sys_settings.svh"

module csr_file (
  input  logic               clk,
  input  logic               rst,
  input  logic               wen,
  input  logic               trap,
  input  logic               mret,
  input  sys_pkg::csr_addr_t raddr,
  input  sys_pkg::csr_addr_t waddr,
  input  sys_pkg::csr_addr_t waddr2,
  input  sys_pkg::xlen_t     wdata,
  input  sys_pkg::xlen_t     wdata2,
  output sys_pkg::xlen_t     rdata,
  output sys_pkg::xlen_t     mtvec,
  output sys_pkg::xlen_t     mepc
);

  sys_pkg::xlen_t mstatus_q;
  sys_pkg::xlen_t mtvec_q;
  sys_pkg::xlen_t mepc_q;
  sys_pkg::xlen_t mcause_q;
  sys_pkg::xlen_t mstatus_nxt;
  sys_pkg::xlen_t mtvec_nxt;
  sys_pkg::xlen_t mepc_nxt;
  sys_pkg::xlen_t mcause_nxt;

  // next value of one stored register from the two write ports.
  // port 2 wins when both ports hit the same address.
  function automatic sys_pkg::xlen_t write_sel(input sys_pkg::xlen_t cur,
                                               input sys_pkg::csr_addr_t addr);
    sys_pkg::xlen_t val;
    val = cur;
    if (wen && (waddr == addr)) begin
      val = wdata;
    end
    if (wen && (waddr2 == addr)) begin
      val = wdata2;
    end
    return val;
  endfunction

  // ********************************************************************
  // write side.
  // ********************************************************************

  always_comb begin
    mtvec_nxt  = write_sel(mtvec_q, `CSR_MTVEC);
    mepc_nxt   = write_sel(mepc_q, `CSR_MEPC);
    mcause_nxt = write_sel(mcause_q, `CSR_MCAUSE);
  end

  always_comb begin
    mstatus_nxt = write_sel(mstatus_q, `CSR_MSTATUS);
    if (trap) begin
      mstatus_nxt[`MSTATUS_MPIE] = mstatus_q[`MSTATUS_MIE];
      mstatus_nxt[`MSTATUS_MIE]  = 1'b0;
    end
    if (mret) begin
      mstatus_nxt[`MSTATUS_MIE]  = mstatus_q[`MSTATUS_MPIE];
      mstatus_nxt[`MSTATUS_MPIE] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_nxt;
      mtvec_q   <= mtvec_nxt;
      mepc_q    <= mepc_nxt;
      mcause_q  <= mcause_nxt;
    end
  end

  // ********************************************************************
  // read side.
  // ********************************************************************

  always_comb begin
    case (raddr)
      `CSR_MSTATUS:   rdata = mstatus_q;
      `CSR_MTVEC:     rdata = mtvec_q;
      `CSR_MEPC:      rdata = mepc_q;
      `CSR_MCAUSE:    rdata = mcause_q;
      `CSR_MVENDORID: rdata = `MVENDORID_VAL;
      `CSR_MARCHID:   rdata = `MARCHID_VAL;
      default:        rdata = '0;  // unmapped addresses read zero.
    endcase
  end

  assign mtvec = mtvec_q;
  assign mepc  = mepc_q;

endmodule

/* src/sys_unit.sv */
`timescale 1ns/10ps

module sys_unit (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  sys_pkg::sys_req_t in_req,
  output logic              out_valid,
  output sys_pkg::sys_res_t out_res
);

  logic               dec_valid;
  sys_pkg::sys_dec_t  dec;
  sys_pkg::csr_addr_t raddr;
  sys_pkg::csr_addr_t waddr;
  sys_pkg::csr_addr_t waddr2;
  sys_pkg::xlen_t     wdata;
  sys_pkg::xlen_t     wdata2;
  sys_pkg::xlen_t     rdata;
  sys_pkg::xlen_t     mtvec;
  sys_pkg::xlen_t     mepc;
  logic               wen;
  logic               trap;
  logic               mret;

  sys_decode i_sys_decode (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  // execute reads and writes the CSR file in the same cycle.
  csr_execute i_csr_execute (
    .clk       (clk),
    .rst       (rst),
    .dec_valid (dec_valid),
    .dec       (dec),
    .rdata     (rdata),
    .mtvec     (mtvec),
    .mepc      (mepc),
    .raddr     (raddr),
    .wen       (wen),
    .trap      (trap),
    .mret      (mret),
    .waddr     (waddr),
    .waddr2    (waddr2),
    .wdata     (wdata),
    .wdata2    (wdata2),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  csr_file i_csr_file (
    .clk    (clk),
    .rst    (rst),
    .wen    (wen),
    .trap   (trap),
    .mret   (mret),
    .raddr  (raddr),
    .waddr  (waddr),
    .waddr2 (waddr2),
    .wdata  (wdata),
    .wdata2 (wdata2),
    .rdata  (rdata),
    .mtvec  (mtvec),
    .mepc   (mepc)
  );

endmodule

/* bench/sys_unit_tb.sv */
`timescale 1ns/10ps
`include "sys_settings.svh"

module sys_unit_tb;

  localparam int RESET_CYCLES   = 3;
  localparam int NUM_TESTS      = 27;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS + 20;

  localparam sys_pkg::xlen_t BASE_PC = 32'h0000_0100;

  localparam logic [2:0] F3_RW  = 3'b001;
  localparam logic [2:0] F3_RS  = 3'b010;
  localparam logic [2:0] F3_RC  = 3'b011;
  localparam logic [2:0] F3_RSI = 3'b110;
  localparam logic [2:0] F3_RCI = 3'b111;

  // one row of the stimulus table with the result it should produce.
  typedef struct packed {
    sys_pkg::instr_t instr;
    sys_pkg::xlen_t  rs1_data;
    sys_pkg::xlen_t  pc;
    logic            exp_rd_wen;
    sys_pkg::xlen_t  exp_rd_data;
    logic            exp_redirect;
    sys_pkg::xlen_t  exp_target;
  } test_vec_t;

  logic              clk;
  logic              rst;
  logic              in_valid;
  sys_pkg::sys_req_t in_req;
  logic              out_valid;
  sys_pkg::sys_res_t out_res;

  test_vec_t vectors [NUM_TESTS];
  string     names [NUM_TESTS];
  int        num_entries = 0;
  int        cycle       = 0;
  int        checked     = 0;
  int        passed      = 0;
  int        failed      = 0;
  int        errors      = 0;
  int        issue_q [$];   // cycle at which each request in flight was sampled.
  sys_pkg::xlen_t ecall_pc;

  sys_unit i_sys_unit (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // **********************************************************************
  // table construction.
  // **********************************************************************

  function automatic sys_pkg::instr_t csr_instr(input logic [2:0] funct3,
                                                input sys_pkg::csr_addr_t addr,
                                                input sys_pkg::reg_idx_t src,
                                                input sys_pkg::reg_idx_t rd);
    return {addr, src, funct3, rd, `SYS_OPCODE};
  endfunction

  task automatic add_entry(input string name, input sys_pkg::instr_t instr,
                           input sys_pkg::xlen_t rs1_data, input logic rd_wen,
                           input sys_pkg::xlen_t rd_data, input logic redirect,
                           input sys_pkg::xlen_t target);
    test_vec_t t;
    t.instr        = instr;
    t.rs1_data     = rs1_data;
    t.pc           = BASE_PC + 4 * num_entries;  // one word per row.
    t.exp_rd_wen   = rd_wen;
    t.exp_rd_data  = rd_data;
    t.exp_redirect = redirect;
    t.exp_target   = target;
    vectors[num_entries] = t;
    names[num_entries]   = name;
    num_entries++;
  endtask

  // expected values follow the CSR state built up row by row.
  task automatic load_table;
    add_entry("rd_mstatus_rst", csr_instr(F3_RS, `CSR_MSTATUS, 0, 1), 0, 1, 0, 0, 0);
    add_entry("rd_mtvec_rst", csr_instr(F3_RS, `CSR_MTVEC, 0, 1), 0, 1, 0, 0, 0);
    add_entry("rd_mepc_rst", csr_instr(F3_RS, `CSR_MEPC, 0, 1), 0, 1, 0, 0, 0);
    add_entry("rd_mcause_rst", csr_instr(F3_RS, `CSR_MCAUSE, 0, 1), 0, 1, 0, 0, 0);
    add_entry("rd_mvendorid", csr_instr(F3_RS, `CSR_MVENDORID, 0, 1), 0, 1,
              `MVENDORID_VAL, 0, 0);
    add_entry("rd_marchid", csr_instr(F3_RS, `CSR_MARCHID, 0, 1), 0, 1, `MARCHID_VAL, 0, 0);
    add_entry("wr_mtvec", csr_instr(F3_RW, `CSR_MTVEC, 3, 2), 32'h0000_1000, 1, 0, 0, 0);
    add_entry("rd_mtvec_new", csr_instr(F3_RS, `CSR_MTVEC, 0, 2), 0, 1, 32'h0000_1000, 0, 0);
    add_entry("set_mstatus_reg", csr_instr(F3_RS, `CSR_MSTATUS, 6, 4), 32'h0000_0088, 1,
              32'h0000_0000, 0, 0);
    add_entry("clr_mstatus_reg", csr_instr(F3_RC, `CSR_MSTATUS, 6, 4), 32'h0000_0080, 1,
              32'h0000_0088, 0, 0);
    add_entry("set_mstatus_imm", csr_instr(F3_RSI, `CSR_MSTATUS, 5'h11, 4), 0, 1,
              32'h0000_0008, 0, 0);
    add_entry("clr_mstatus_imm", csr_instr(F3_RCI, `CSR_MSTATUS, 5'h01, 4), 0, 1,
              32'h0000_0019, 0, 0);
    add_entry("rs_zero_src", csr_instr(F3_RS, `CSR_MSTATUS, 0, 4), 32'hffff_ffff, 1,
              32'h0000_0018, 0, 0);
    add_entry("rc_zero_imm", csr_instr(F3_RCI, `CSR_MSTATUS, 0, 4), 0, 1, 32'h0000_0018, 0, 0);
    add_entry("rd_mstatus", csr_instr(F3_RS, `CSR_MSTATUS, 0, 4), 0, 1, 32'h0000_0018, 0, 0);
    add_entry("wr_mvendorid", csr_instr(F3_RW, `CSR_MVENDORID, 8, 7), 32'h1234_5678, 1,
              `MVENDORID_VAL, 0, 0);
    add_entry("rd_mvendorid_again", csr_instr(F3_RS, `CSR_MVENDORID, 0, 7), 0, 1,
              `MVENDORID_VAL, 0, 0);
    ecall_pc = BASE_PC + 4 * num_entries;
    add_entry("ecall", `INSTR_ECALL, 0, 0, 0, 1, 32'h0000_1000);
    add_entry("rd_mepc_trap", csr_instr(F3_RS, `CSR_MEPC, 0, 9), 0, 1, ecall_pc, 0, 0);
    add_entry("rd_mcause_trap", csr_instr(F3_RS, `CSR_MCAUSE, 0, 9), 0, 1,
              `CAUSE_ECALL_M, 0, 0);
    add_entry("rd_mstatus_trap", csr_instr(F3_RS, `CSR_MSTATUS, 0, 9), 0, 1,
              32'h0000_0090, 0, 0);   // MIE cleared, MPIE holds the old MIE.
    add_entry("mret", `INSTR_MRET, 0, 0, 0, 1, ecall_pc);
    add_entry("rd_mstatus_mret", csr_instr(F3_RS, `CSR_MSTATUS, 0, 9), 0, 1,
              32'h0000_0098, 0, 0);
    add_entry("unknown_addi", 32'h00a0_0093, 32'h0000_0055, 0, 0, 0, 0);
    add_entry("unknown_ebreak", 32'h0010_0073, 0, 0, 0, 0, 0);
    add_entry("rd_mepc_final", csr_instr(F3_RS, `CSR_MEPC, 0, 10), 0, 1, ecall_pc, 0, 0);
    add_entry("rd_mstatus_final", csr_instr(F3_RS, `CSR_MSTATUS, 0, 10), 0, 1,
              32'h0000_0098, 0, 0);
  endtask

  // **********************************************************************
  // result checking.
  // **********************************************************************

  task automatic check_result(input int idx, input int issued);
    test_vec_t t;
    int        bad;
    t   = vectors[idx];
    bad = 0;
    assert (cycle == issued + 2) else begin
      $display("test %s: result came out at cycle %0d instead of cycle %0d",
               names[idx], cycle, issued + 2);
      bad++;
    end
    assert (out_res.rd_wen == t.exp_rd_wen) else begin
      $display("ERROR %s rd_wen expected %0b actual %0b", names[idx], t.exp_rd_wen,
               out_res.rd_wen);
      bad++;
    end
    if (t.exp_rd_wen) begin
      // the destination is the rd field of the instruction word.
      assert (out_res.rd == t.instr[11:7]) else begin
        $display("ERROR %s rd expected %0d actual %0d", names[idx], t.instr[11:7],
                 out_res.rd);
        bad++;
      end
      assert (out_res.rd_data == t.exp_rd_data) else begin
        $display("ERROR %s rd_data expected %h actual %h", names[idx], t.exp_rd_data,
                 out_res.rd_data);
        bad++;
      end
    end
    assert (out_res.redirect == t.exp_redirect) else begin
      $display("ERROR %s redirect expected %0b actual %0b", names[idx], t.exp_redirect,
               out_res.redirect);
      bad++;
    end
    if (t.exp_redirect) begin
      assert (out_res.target == t.exp_target) else begin
        $display("ERROR %s target expected %h actual %h", names[idx], t.exp_target,
                 out_res.target);
        bad++;
      end
    end
    errors += bad;
    if (bad == 0) begin
      passed++;
      $display("test %0d %s: ok", idx, names[idx]);
    end else begin
      failed++;
      $display("test %0d %s: failed with %0d error(s)", idx, names[idx], bad);
    end
  endtask

  // sampled on the falling edge, away from the driving edge.
  always @(negedge clk) begin
    if (!rst && out_valid) begin
      assert (issue_q.size() != 0) else begin
        $display("out_valid was high with no request in flight at cycle %0d", cycle);
        errors++;
      end
      if (issue_q.size() != 0) begin
        check_result(checked, issue_q.pop_front());
        checked++;
      end
    end
    if (!rst && in_valid) issue_q.push_back(cycle);
  end

  // **********************************************************************
  // stimulus and end of run.
  // **********************************************************************

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    in_req   = '0;
    load_table();
    assert (num_entries == NUM_TESTS) else begin
      $display("the stimulus table holds %0d rows but %0d were expected",
               num_entries, NUM_TESTS);
      errors++;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      @(posedge clk);
      in_valid        <= 1'b1;
      in_req.pc       <= vectors[i].pc;
      in_req.instr    <= vectors[i].instr;
      in_req.rs1_data <= vectors[i].rs1_data;
    end
    @(posedge clk);
    in_valid <= 1'b0;
    in_req   <= '0;
    wait (checked == NUM_TESTS);
    repeat (2) @(negedge clk);   // catch any stray result after the last one.
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", checked, passed, failed,
             errors);
    if (errors == 0 && failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    while (cycle < TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d results checked", cycle, checked,
             NUM_TESTS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* sys_unit.f */
+incdir+src
src/sys_pkg.sv
src/sys_decode.sv
src/csr_execute.sv
src/csr_file.sv
src/sys_unit.sv
bench/sys_unit_tb.sv

/* Makefile */
TOP = sys_unit_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sys_unit.f
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
